/* logic/sample_pkg.sv */
`default_nettype none

package sample_pkg;

	// widths that the rest of the design derives its types from
	localparam int unsigned SAMPLE_WIDTH   = 16;
	localparam int unsigned SAMPLE_BYTES   = SAMPLE_WIDTH / 8;
	localparam int unsigned BUS_WIDTH      = 32;
	localparam int unsigned BUS_BYTES      = BUS_WIDTH / 8;
	localparam int unsigned BUS_ADDR_WIDTH = 16;

	typedef logic [SAMPLE_WIDTH-1:0]   sample_t;   // one stored sample
	typedef logic [BUS_WIDTH-1:0]      bus_data_t; // bus data word
	typedef logic [BUS_BYTES-1:0]      bus_strb_t; // bus byte mask
	typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t; // word address, ram takes the low bits
	typedef logic [SAMPLE_BYTES-1:0]   byte_en_t;  // ram byte enable

	// register bus request, sampled on every edge with req high
	typedef struct packed {
		logic      req;
		logic      we;
		bus_addr_t addr;
		bus_data_t wdata;
		bus_strb_t wmask;
	} bus_req_t;

	// register bus response, rvalid is a single-cycle pulse
	typedef struct packed {
		logic      rvalid;
		bus_data_t rdata;
	} bus_rsp_t;

	// write command for ram port A
	typedef struct packed {
		logic      en;
		byte_en_t  be;
		bus_addr_t addr;
		sample_t   data;
	} port_a_t;

	// read command for ram port B
	typedef struct packed {
		logic      en;
		bus_addr_t addr;
	} port_b_t;

endpackage

`default_nettype wire

/* logic/sample_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_ram #(
	parameter int unsigned ADDR_WIDTH = 10
) (
	input  wire logic                clk_i,
	input  wire logic                rst_ni,
	input  wire sample_pkg::port_a_t port_a_i,  // write command
	input  wire sample_pkg::port_b_t port_b_i,  // read command
	output sample_pkg::sample_t      rd_data_o  // registered port B data
);

	import sample_pkg::*;

	localparam int unsigned DEPTH = 2 ** ADDR_WIDTH;

	typedef logic [ADDR_WIDTH-1:0] ram_addr_t;

	sample_t   mem [DEPTH];
	ram_addr_t addr_a;
	ram_addr_t addr_b;

	// only the low address bits select a word
	assign addr_a = port_a_i.addr[ADDR_WIDTH-1:0];
	assign addr_b = port_b_i.addr[ADDR_WIDTH-1:0];

	// byte-masked write on port A
	always_ff @(posedge clk_i) begin
		if (port_a_i.en) begin
			for (int unsigned i = 0; i < SAMPLE_BYTES; i++) begin
				if (port_a_i.be[i]) begin
					mem[addr_a][i*8 +: 8] <= port_a_i.data[i*8 +: 8];
				end
			end
		end
	end

	// registered read on port B
	// a write to the same word on the same edge is not seen yet (read-first)
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_data_o <= '0;
		end else if (port_b_i.en) begin
			rd_data_o <= mem[addr_b];
		end
	end

endmodule

`default_nettype wire

/* logic/access_select.sv */
`timescale 1ns/1ns
`default_nettype none

module access_select #(
	parameter int unsigned ADDR_WIDTH = 10
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_ni,

	// stream writer
	input  wire logic                  wr_en_i,
	input  wire logic [ADDR_WIDTH-1:0] wr_addr_i,
	input  wire sample_pkg::sample_t   wr_data_i,

	// stream reader
	input  wire logic                  rd_en_i,
	input  wire logic [ADDR_WIDTH-1:0] rd_addr_i,

	// register bus
	input  wire sample_pkg::bus_req_t  bus_req_i,

	// ram commands, one cycle after the inputs
	output sample_pkg::port_a_t        port_a_o,
	output sample_pkg::port_b_t        port_b_o,
	output logic                       rd_issue_o  // one pulse per accepted bus read
);

	import sample_pkg::*;

	port_a_t port_a_d;
	port_a_t port_a_q;
	port_b_t port_b_d;
	port_b_t port_b_q;
	logic    bus_wr;
	logic    bus_rd;
	logic    rd_issue_q;

	assign bus_wr = bus_req_i.req && bus_req_i.we;
	assign bus_rd = bus_req_i.req && !bus_req_i.we;

	// port A, the bus write has priority over the stream write
	always_comb begin
		port_a_d.en   = wr_en_i;
		port_a_d.be   = '1;                   // stream writes whole samples
		port_a_d.addr = bus_addr_t'(wr_addr_i);
		port_a_d.data = wr_data_i;

		if (bus_wr) begin
			// only the low bus bytes reach the sample, upper lanes are dropped
			port_a_d.be   = bus_req_i.wmask[SAMPLE_BYTES-1:0];
			port_a_d.en   = |bus_req_i.wmask[SAMPLE_BYTES-1:0];
			port_a_d.addr = bus_req_i.addr;
			port_a_d.data = bus_req_i.wdata[SAMPLE_WIDTH-1:0];
		end
	end

	// port B, any bus request takes the read port
	// a bus write still moves the address, the stream read is lost for that cycle
	always_comb begin
		port_b_d.en   = rd_en_i;
		port_b_d.addr = bus_addr_t'(rd_addr_i);

		if (bus_req_i.req) begin
			port_b_d.en   = 1'b1;
			port_b_d.addr = bus_req_i.addr;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			port_a_q   <= '0;
			port_b_q   <= '0;
			rd_issue_q <= 1'b0;
		end else begin
			port_a_q   <= port_a_d;
			port_b_q   <= port_b_d;
			rd_issue_q <= bus_rd;
		end
	end

	assign port_a_o   = port_a_q;
	assign port_b_o   = port_b_q;
	assign rd_issue_o = rd_issue_q;

endmodule

`default_nettype wire

/* logic/bus_response.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_response (
	input  wire logic                clk_i,
	input  wire logic                rst_ni,
	input  wire logic                rd_issue_i,  // bus read sent to the ram this cycle
	input  wire sample_pkg::sample_t ram_data_i,  // ram port B output
	output sample_pkg::bus_rsp_t     bus_rsp_o
);

	import sample_pkg::*;

	logic     rd_pending_q; // read is in the ram stage
	bus_rsp_t rsp_d;
	bus_rsp_t rsp_q;

	// follows the read through the ram cycle so it lines up with ram_data_i
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_pending_q <= 1'b0;
		end else begin
			rd_pending_q <= rd_issue_i;
		end
	end

	// data is zero whenever there is no response
	always_comb begin
		rsp_d.rvalid = rd_pending_q;
		rsp_d.rdata  = '0;
		if (rd_pending_q) begin
			rsp_d.rdata = bus_data_t'(ram_data_i); // upper half reads as zero
		end
	end

	// two reads can be in flight, one in each register, back-to-back is fine
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rsp_q <= '0;
		end else begin
			rsp_q <= rsp_d;
		end
	end

	assign bus_rsp_o = rsp_q;

endmodule

`default_nettype wire

/* logic/sample_buffer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_top #(
	parameter int unsigned ADDR_WIDTH = 10
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_ni,

	// stream writer
	input  wire logic                  wr_en_i,
	input  wire logic [ADDR_WIDTH-1:0] wr_addr_i,
	input  wire sample_pkg::sample_t   wr_data_i,

	// stream reader, data one cycle after the request
	input  wire logic                  rd_en_i,
	input  wire logic [ADDR_WIDTH-1:0] rd_addr_i,
	output sample_pkg::sample_t        rd_data_o,

	// register bus, read data two cycles after the request
	input  wire sample_pkg::bus_req_t  bus_req_i,
	output sample_pkg::bus_rsp_t       bus_rsp_o
);

	import sample_pkg::*;

	port_a_t port_a;
	port_b_t port_b;
	logic    rd_issue;
	sample_t ram_rd_data;

	// stage 1, merge bus and stream commands
	access_select #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_access_select (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.wr_en_i    (wr_en_i),
		.wr_addr_i  (wr_addr_i),
		.wr_data_i  (wr_data_i),
		.rd_en_i    (rd_en_i),
		.rd_addr_i  (rd_addr_i),
		.bus_req_i  (bus_req_i),
		.port_a_o   (port_a),
		.port_b_o   (port_b),
		.rd_issue_o (rd_issue)
	);

	// stage 2, the memory itself
	sample_ram #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_sample_ram (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.port_a_i  (port_a),
		.port_b_i  (port_b),
		.rd_data_o (ram_rd_data)
	);

	// stage 3, bus read data
	bus_response u_bus_response (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.rd_issue_i (rd_issue),
		.ram_data_i (ram_rd_data),
		.bus_rsp_o  (bus_rsp_o)
	);

	assign rd_data_o = ram_rd_data; // stream reader shares port B with the bus

endmodule

`default_nettype wire

/* tb/sample_buffer_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_assert (
	input wire logic                 clk_i,
	input wire logic                 rst_ni,
	input wire sample_pkg::bus_req_t bus_req_i,
	input wire sample_pkg::bus_rsp_t bus_rsp_o
);

	import sample_pkg::*;

	// a read sampled at edge k shows rvalid between edges k+2 and k+3
	rvalid_follows_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_rsp_o.rvalid == $past(bus_req_i.req && !bus_req_i.we, 3))
		else $error("rvalid does not line up with a bus read two cycles earlier");

	upper_rdata_zero: assert property (@(posedge clk_i)
		bus_rsp_o.rdata[31:16] == '0)
		else $error("upper half of rdata is not zero");

	no_rvalid_in_reset: assert property (@(posedge clk_i)
		!rst_ni |-> !bus_rsp_o.rvalid)
		else $error("rvalid high while in reset");

endmodule

bind sample_buffer_top sample_buffer_assert u_sample_buffer_assert (
	.clk_i     (clk_i),
	.rst_ni    (rst_ni),
	.bus_req_i (bus_req_i),
	.bus_rsp_o (bus_rsp_o)
);

`default_nettype wire

/* tb/sample_buffer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_buffer_tb;

	import sample_pkg::*;

	localparam int unsigned ADDR_WIDTH = 10;
	localparam int unsigned DEPTH      = 2 ** ADDR_WIDTH;
	localparam int unsigned DRAIN_MAX  = 8;  // cycles allowed for the last responses

	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// one table row with stimulus and what the outputs must show later
	typedef struct packed {
		logic     wr_en;
		addr_t    wr_addr;
		sample_t  wr_data;
		logic     rd_en;
		addr_t    rd_addr;
		bus_req_t bus_req;
		logic     chk_rd;   // 0 means don't check
		sample_t  exp_rd;
		logic     chk_rsp;
		bus_rsp_t exp_rsp;
	} entry_t;

	logic     clk_i;
	logic     rst_ni;
	logic     wr_en_i;
	addr_t    wr_addr_i;
	sample_t  wr_data_i;
	logic     rd_en_i;
	addr_t    rd_addr_i;
	sample_t  rd_data_o;
	bus_req_t bus_req_i;
	bus_rsp_t bus_rsp_o;

	entry_t      stim_q[$];
	entry_t      rd_pipe[$];  // stream read data checked one cycle after sampling
	entry_t      rsp_pipe[$]; // bus responses checked two cycles after sampling
	int unsigned rd_due[$];
	int unsigned rsp_due[$];
	int unsigned cyc;
	logic [31:0] lfsr_state;

	sample_t ref_mem [DEPTH];   // reference memory
	logic    ref_known [DEPTH]; // word fully written at least once
	sample_t ref_rd;            // what port B holds
	logic    ref_rd_known;

	sample_buffer_top #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) uut (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.wr_en_i   (wr_en_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_data_i),
		.rd_en_i   (rd_en_i),
		.rd_addr_i (rd_addr_i),
		.rd_data_o (rd_data_o),
		.bus_req_i (bus_req_i),
		.bus_rsp_o (bus_rsp_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int unsigned nbits);
		logic [31:0] v;
		v = '0;
		for (int unsigned i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic bus_req_t make_read(input addr_t a);
		bus_req_t r;
		r = '0;
		r.req = 1'b1;
		r.addr = bus_addr_t'(a);
		return r;
	endfunction

	function automatic bus_req_t make_write(input addr_t a, input bus_data_t d,
			input bus_strb_t m);
		bus_req_t r;
		r = make_read(a);
		r.we = 1'b1;
		r.wdata = d;
		r.wmask = m;
		return r;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
				$time, name, exp, act));
		end
	endtask

	// applies the priority and byte-mask rules to the reference and queues the row
	task automatic add_entry(input logic wr_en, input addr_t wr_addr, input sample_t wr_data,
			input logic rd_en, input addr_t rd_addr, input bus_req_t req);
		entry_t e;
		addr_t  ba;
		e = '0;
		e.wr_en = wr_en;
		e.wr_addr = wr_addr;
		e.wr_data = wr_data;
		e.rd_en = rd_en;
		e.rd_addr = rd_addr;
		e.bus_req = req;
		ba = req.addr[ADDR_WIDTH-1:0];
		// port B reads before this row's write lands (read-first)
		if (req.req) begin
			ref_rd = ref_mem[ba];
			ref_rd_known = ref_known[ba];
		end else if (rd_en) begin
			ref_rd = ref_mem[rd_addr];
			ref_rd_known = ref_known[rd_addr];
		end
		e.chk_rd = ref_rd_known;
		e.exp_rd = ref_rd;
		e.chk_rsp = 1'b1; // rvalid low and rdata zero when no read
		if (req.req && !req.we) begin
			e.exp_rsp.rvalid = 1'b1;
			e.exp_rsp.rdata = bus_data_t'(ref_mem[ba]);
			e.chk_rsp = ref_known[ba];
		end
		if (req.req && req.we) begin // bus wins port A and mask bits 2 and 3 have no byte
			if (req.wmask[0]) ref_mem[ba][7:0] = req.wdata[7:0];
			if (req.wmask[1]) ref_mem[ba][15:8] = req.wdata[15:8];
			if (req.wmask[1:0] == 2'b11) ref_known[ba] = 1'b1;
		end else if (wr_en) begin
			ref_mem[wr_addr] = wr_data;
			ref_known[wr_addr] = 1'b1;
		end
		stim_q.push_back(e);
	endtask

	task automatic build_table();
		sample_t  d;
		addr_t    a;
		addr_t    ra;
		logic     w;
		logic     r;
		for (int unsigned i = 0; i < 8; i++) begin
			d = sample_t'(take_bits(16));
			add_entry(1'b1, addr_t'(i), d, 1'b0, '0, '0);
		end
		for (int unsigned i = 0; i < 8; i++) add_entry(1'b0, '0, '0, 1'b1, addr_t'(i), '0);
		// bus writes with a full mask then single bytes then upper lanes only
		add_entry(1'b0, '0, '0, 1'b0, '0, make_write(20, 32'hffff_a5c3, 4'b0011));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_read(20));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_write(20, 32'h0000_0011, 4'b0001));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_read(20));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_write(20, 32'h0000_2200, 4'b0010));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_read(20));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_write(20, 32'hffff_ffff, 4'b1100));
		add_entry(1'b0, '0, '0, 1'b0, '0, make_read(20));
		// bus write and stream write in one cycle
		add_entry(1'b1, 30, 16'h3030, 1'b0, '0, '0);
		add_entry(1'b1, 31, 16'h3131, 1'b0, '0, '0);
		add_entry(1'b1, 30, 16'hbeef, 1'b0, '0, make_write(31, 32'h0000_7777, 4'b0011));
		add_entry(1'b0, '0, '0, 1'b1, 30, '0);
		add_entry(1'b0, '0, '0, 1'b1, 31, '0);
		// back-to-back reads and then bus requests taking the stream read port
		for (int unsigned i = 0; i < 4; i++) begin
			add_entry(1'b0, '0, '0, 1'b0, '0, make_read(addr_t'(i)));
		end
		add_entry(1'b0, '0, '0, 1'b1, 7, make_read(5));
		add_entry(1'b0, '0, '0, 1'b1, 7, make_write(6, 32'h0000_6666, 4'b0011));
		add_entry(1'b0, '0, '0, 1'b1, 6, '0);
		// bulk fill of every word then random traffic
		for (int unsigned i = 0; i < DEPTH; i++) begin
			d = sample_t'(take_bits(16));
			add_entry(1'b1, addr_t'(i), d, 1'b0, '0, '0);
		end
		for (int unsigned n = 0; n < 400; n++) begin
			w = 1'(take_bits(1));
			a = addr_t'(take_bits(ADDR_WIDTH));
			d = sample_t'(take_bits(16));
			r = 1'(take_bits(1));
			ra = addr_t'(take_bits(ADDR_WIDTH));
			if (r) begin
				add_entry(w, a, d, 1'b1, ra, '0);
			end else begin
				add_entry(w, a, d, 1'b0, '0, make_read(ra));
			end
		end
	endtask

	task automatic compare_pending();
		entry_t e;
		if (rd_pipe.size() != 0 && rd_due[0] == cyc) begin
			e = rd_pipe.pop_front();
			rd_due.delete(0);
			if (e.chk_rd) check_sample("rd_data_o", e.exp_rd, rd_data_o);
		end
		if (rsp_pipe.size() != 0 && rsp_due[0] == cyc) begin
			e = rsp_pipe.pop_front();
			rsp_due.delete(0);
			if (e.chk_rsp) check_rsp("bus_rsp_o", e.exp_rsp, bus_rsp_o);
		end
	endtask

	// on each falling edge check what is due and drive the next row
	task automatic step_cycle(input entry_t e, input logic track);
		@(negedge clk_i);
		cyc++;
		compare_pending();
		wr_en_i   = e.wr_en;
		wr_addr_i = e.wr_addr;
		wr_data_i = e.wr_data;
		rd_en_i   = e.rd_en;
		rd_addr_i = e.rd_addr;
		bus_req_i = e.bus_req;
		if (track) begin
			rd_pipe.push_back(e);
			rd_due.push_back(cyc + 2);
			rsp_pipe.push_back(e);
			rsp_due.push_back(cyc + 3);
		end
	endtask

	initial begin
		int unsigned wait_cyc;
		lfsr_state = 32'h3287_88a4;
		cyc = 0;
		rst_ni = 1'b0;
		wr_en_i = 1'b0;
		wr_addr_i = '0;
		wr_data_i = '0;
		rd_en_i = 1'b0;
		rd_addr_i = '0;
		bus_req_i = '0;
		for (int unsigned i = 0; i < DEPTH; i++) ref_known[i] = 1'b0;
		ref_rd = '0;
		ref_rd_known = 1'b1; // output register clears in reset
		build_table();
		for (int unsigned i = 0; i < 5; i++) @(negedge clk_i);
		rst_ni = 1'b1;
		check_rsp("bus_rsp_o", '0, bus_rsp_o);
		check_sample("rd_data_o", '0, rd_data_o);
		foreach (stim_q[i]) step_cycle(stim_q[i], 1'b1);
		wait_cyc = 0;
		while ((rd_pipe.size() != 0 || rsp_pipe.size() != 0) && wait_cyc < DRAIN_MAX) begin
			step_cycle('0, 1'b0);
			wait_cyc++;
		end
		if (rd_pipe.size() != 0 || rsp_pipe.size() != 0) begin
			stop_on_error("timeout: expected outputs still pending after the drain cycles");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* project.f */
logic/sample_pkg.sv
logic/sample_ram.sv
logic/access_select.sv
logic/bus_response.sv
logic/sample_buffer_top.sv
tb/sample_buffer_assert.sv
tb/sample_buffer_tb.sv

/* Bender.yml */
package:
  name: sample_buffer

sources:
  # package first, the rtl modules import it
  - files:
      - logic/sample_pkg.sv
      - logic/sample_ram.sv
      - logic/access_select.sv
      - logic/bus_response.sv
      - logic/sample_buffer_top.sv

  - target: test
    files:
      - tb/sample_buffer_assert.sv
      - tb/sample_buffer_tb.sv
